// File: src/mem_attach_macros.svh
`ifndef MEM_ATTACH_MACROS_SVH
`define MEM_ATTACH_MACROS_SVH

// default OPB address window of the memory attachment
`define MEM_BASEADDR 32'h8000_0000
`define MEM_HIGHADDR 32'h80FF_FFFF

// controller command codes
`define DRAM_CMD_WR_CODE 3'b000
`define DRAM_CMD_RD_CODE 3'b001

// beats per controller burst
`define DRAM_BURST_LEN 2

`endif

// File: src/opb_pkg.sv
package opb_pkg;

   // big-endian bus word, bit 0 is the msb
   typedef logic [0:31] opb_word_t;

   // bus-side access states
   typedef enum logic [3:0] {
      OPB_IDLE  = 4'h0,   // waiting for select
      OPB_READ  = 4'h1,   // read request pending
      OPB_WRITE = 4'h2,   // write request pending
      OPB_DONE  = 4'h3    // ack sent, dropping request
   } opb_state_e;

endpackage

// File: src/dram_pkg.sv
`include "mem_attach_macros.svh"

package dram_pkg;

   typedef logic [287:0] dram_beat_t;   // one controller data beat
   typedef logic [35:0]  dram_mask_t;   // 1 = byte masked

   typedef enum logic [2:0] {
      DRAM_CMD_WRITE = `DRAM_CMD_WR_CODE,
      DRAM_CMD_READ  = `DRAM_CMD_RD_CODE
   } dram_cmd_e;

   // controller-side access states
   typedef enum logic [3:0] {
      DRAM_IDLE        = 4'h0,
      DRAM_READ_INIT   = 4'h1,
      DRAM_READ_HOLD   = 4'h2,   // command held until rdy
      DRAM_READ_WAIT   = 4'h3,   // waiting on read beats
      DRAM_READ_RESP   = 4'h4,
      DRAM_WRITE_INIT  = 4'h5,
      DRAM_WRITE_HOLD  = 4'h6,   // command held until rdy
      DRAM_WRITE_BEAT1 = 4'h7,
      DRAM_WRITE_BEAT2 = 4'h8,
      DRAM_WRITE_RESP  = 4'h9
   } dram_state_e;

endpackage

// File: src/opb_slave_fsm.sv
`timescale 1ns/100ps
`include "mem_attach_macros.svh"

module opb_slave_fsm #(
   parameter logic [31:0] C_BASEADDR = `MEM_BASEADDR,
   parameter logic [31:0] C_HIGHADDR = `MEM_HIGHADDR
) (
   input  logic                   OPB_Clk,
   input  logic                   dram_rst,

   // bus master side
   input  opb_pkg::opb_word_t     OPB_ABus,
   input  logic [0:3]             OPB_BE,
   input  opb_pkg::opb_word_t     OPB_DBus,
   input  logic                   OPB_RNW,
   input  logic                   OPB_select,
   output opb_pkg::opb_word_t     Sl_DBus,
   output logic                   Sl_xferAck,
   output logic                   Sl_toutSup,

   // handshake to the controller-side fsm
   output logic                   rd_req,
   output logic                   wr_req,
   input  logic                   rd_done,
   input  logic                   wr_done,
   input  opb_pkg::opb_word_t     rd_data,
   output logic [31:0]            req_addr,
   output opb_pkg::opb_word_t     wr_data,
   output logic [0:3]             wr_be,

   output opb_pkg::opb_state_e    cpu_state
);

   import opb_pkg::*;

   opb_state_e state;
   logic       in_window;

   // only this block decides whether an access belongs to us
   assign in_window = (OPB_ABus >= C_BASEADDR) && (OPB_ABus <= C_HIGHADDR);

   assign cpu_state = state;

   // request payload, latched once per access
   always_ff @(posedge OPB_Clk) begin
      if (state == OPB_IDLE && OPB_select && in_window) begin
         req_addr <= OPB_ABus - C_BASEADDR;   // byte offset into window
         wr_data  <= OPB_DBus;
         wr_be    <= OPB_BE;
      end
   end

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state      <= OPB_IDLE;
         Sl_xferAck <= 1'b0;
         Sl_DBus    <= '0;
         Sl_toutSup <= 1'b0;
         rd_req     <= 1'b0;
         wr_req     <= 1'b0;
      end else begin
         Sl_xferAck <= 1'b0;   // single-cycle pulse
         Sl_DBus    <= '0;     // bus data only during ack

         case (state)
            OPB_IDLE: begin
               if (OPB_select && in_window) begin
                  Sl_toutSup <= 1'b1;   // hold off master timeout
                  if (OPB_RNW) begin
                     rd_req <= 1'b1;
                     state  <= OPB_READ;
                  end else begin
                     wr_req <= 1'b1;
                     state  <= OPB_WRITE;
                  end
               end
            end

            OPB_READ: begin
               if (rd_done) begin
                  Sl_xferAck <= 1'b1;
                  Sl_DBus    <= rd_data;
                  Sl_toutSup <= 1'b0;
                  state      <= OPB_DONE;
               end
            end

            OPB_WRITE: begin
               if (wr_done) begin
                  Sl_xferAck <= 1'b1;
                  Sl_toutSup <= 1'b0;
                  state      <= OPB_DONE;
               end
            end

            OPB_DONE: begin
               // master still has select up this cycle
               rd_req <= 1'b0;
               wr_req <= 1'b0;
               state  <= OPB_IDLE;
            end

            default: begin
               rd_req     <= 1'b0;
               wr_req     <= 1'b0;
               Sl_toutSup <= 1'b0;
               state      <= OPB_IDLE;
            end
         endcase
      end
   end

endmodule

// File: src/dram_access_fsm.sv
`timescale 1ns/100ps
`include "mem_attach_macros.svh"

module dram_access_fsm (
   input  logic                   OPB_Clk,
   input  logic                   dram_rst,

   // handshake from the bus-side fsm
   input  logic                   rd_req,
   input  logic                   wr_req,
   input  logic [31:0]            req_addr,
   input  opb_pkg::opb_word_t     wr_data,
   input  logic [0:3]             wr_be,
   output logic                   rd_done,
   output logic                   wr_done,
   output opb_pkg::opb_word_t     rd_data,

   // memory controller user interface
   input  dram_pkg::dram_beat_t   dram_rd_data,
   input  logic                   dram_rd_data_end,
   input  logic                   dram_rd_data_valid,
   input  logic                   dram_rdy,
   input  logic                   dram_wdf_rdy,
   output logic [31:0]            dram_addr,
   output dram_pkg::dram_cmd_e    dram_cmd,
   output logic                   dram_en,
   output dram_pkg::dram_beat_t   dram_wdf_data,
   output logic                   dram_wdf_end,
   output dram_pkg::dram_mask_t   dram_wdf_mask,
   output logic                   dram_wdf_wren,

   output dram_pkg::dram_state_e  dram_state
);

   import dram_pkg::*;

   dram_state_e state;
   logic [1:0]  rd_beat_cnt;   // read beats seen in this burst
   logic        rd_last_beat;

   assign dram_state = state;

   // end flag normally marks the last beat, the count is a backstop
   assign rd_last_beat = dram_rd_data_end || (rd_beat_cnt == `DRAM_BURST_LEN - 1);

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state         <= DRAM_IDLE;
         rd_done       <= 1'b0;
         wr_done       <= 1'b0;
         dram_en       <= 1'b0;
         dram_wdf_wren <= 1'b0;
         dram_wdf_end  <= 1'b0;
         rd_beat_cnt   <= 2'd0;
      end else begin
         case (state)
            DRAM_IDLE: begin
               if (rd_req) begin
                  state <= DRAM_READ_INIT;
               end else if (wr_req) begin
                  state <= DRAM_WRITE_INIT;
               end
            end

            DRAM_READ_INIT: begin
               dram_addr   <= req_addr;
               dram_cmd    <= DRAM_CMD_READ;
               dram_en     <= 1'b1;
               rd_beat_cnt <= 2'd0;
               state       <= DRAM_READ_HOLD;
            end

            DRAM_READ_HOLD: begin
               if (dram_rdy) begin
                  dram_en <= 1'b0;   // command taken
                  state   <= DRAM_READ_WAIT;
               end
            end

            DRAM_READ_WAIT: begin
               if (dram_rd_data_valid) begin
                  if (rd_beat_cnt == 2'd0) begin
                     rd_data <= dram_rd_data[31:0];   // low word of first beat
                  end
                  rd_beat_cnt <= rd_beat_cnt + 2'd1;
                  if (rd_last_beat) begin
                     rd_done <= 1'b1;
                     state   <= DRAM_READ_RESP;
                  end
               end
            end

            DRAM_READ_RESP: begin
               // done stays up until the request falls
               if (!rd_req) begin
                  rd_done <= 1'b0;
                  state   <= DRAM_IDLE;
               end
            end

            DRAM_WRITE_INIT: begin
               dram_addr <= req_addr;
               dram_cmd  <= DRAM_CMD_WRITE;
               dram_en   <= 1'b1;
               state     <= DRAM_WRITE_HOLD;
            end

            DRAM_WRITE_HOLD: begin
               if (dram_rdy) begin
                  dram_en       <= 1'b0;
                  dram_wdf_wren <= 1'b1;
                  dram_wdf_end  <= 1'b0;
                  // OPB bit 0 lands on beat bit 31
                  dram_wdf_data <= {256'd0, wr_data};
                  // only the enabled bytes of the low word are written
                  dram_wdf_mask <= {32'hFFFF_FFFF, ~wr_be};
                  state         <= DRAM_WRITE_BEAT1;
               end
            end

            DRAM_WRITE_BEAT1: begin
               if (dram_wdf_rdy) begin
                  dram_wdf_data <= '0;
                  dram_wdf_mask <= '1;   // second beat writes nothing
                  dram_wdf_end  <= 1'b1;
                  state         <= DRAM_WRITE_BEAT2;
               end
            end

            DRAM_WRITE_BEAT2: begin
               if (dram_wdf_rdy) begin
                  dram_wdf_wren <= 1'b0;
                  dram_wdf_end  <= 1'b0;
                  wr_done       <= 1'b1;
                  state         <= DRAM_WRITE_RESP;
               end
            end

            DRAM_WRITE_RESP: begin
               if (!wr_req) begin
                  wr_done <= 1'b0;
                  state   <= DRAM_IDLE;
               end
            end

            default: begin
               dram_en       <= 1'b0;
               dram_wdf_wren <= 1'b0;
               dram_wdf_end  <= 1'b0;
               rd_done       <= 1'b0;
               wr_done       <= 1'b0;
               state         <= DRAM_IDLE;
            end
         endcase
      end
   end

endmodule

// File: src/mem_opb_attach.sv
`timescale 1ns/100ps
`include "mem_attach_macros.svh"

module mem_opb_attach #(
   parameter logic [31:0] C_BASEADDR = `MEM_BASEADDR,
   parameter logic [31:0] C_HIGHADDR = `MEM_HIGHADDR
) (
   input  logic                   OPB_Clk,
   input  logic                   dram_rst,

   // OPB slave port
   input  opb_pkg::opb_word_t     OPB_ABus,
   input  logic [0:3]             OPB_BE,
   input  opb_pkg::opb_word_t     OPB_DBus,
   input  logic                   OPB_RNW,
   input  logic                   OPB_select,
   input  logic                   OPB_seqAddr,   // bursts not supported
   output opb_pkg::opb_word_t     Sl_DBus,
   output logic                   Sl_errAck,
   output logic                   Sl_retry,
   output logic                   Sl_toutSup,
   output logic                   Sl_xferAck,

   // DDR3 controller user port
   input  dram_pkg::dram_beat_t   dram_rd_data,
   input  logic                   dram_rd_data_end,
   input  logic                   dram_rd_data_valid,
   input  logic                   dram_rdy,
   input  logic                   dram_wdf_rdy,
   output logic [31:0]            dram_addr,
   output dram_pkg::dram_cmd_e    dram_cmd,
   output logic                   dram_en,
   output dram_pkg::dram_beat_t   dram_wdf_data,
   output logic                   dram_wdf_end,
   output dram_pkg::dram_mask_t   dram_wdf_mask,
   output logic                   dram_wdf_wren,

   // debug
   output dram_pkg::dram_state_e  dram_state,
   output opb_pkg::opb_state_e    cpu_state
);

   import opb_pkg::*;

   // four-phase handshake between the two fsms
   logic        rd_req;
   logic        wr_req;
   logic        rd_done;
   logic        wr_done;
   logic [31:0] req_addr;
   opb_word_t   wr_data;
   logic [0:3]  wr_be;
   opb_word_t   rd_data;

   assign Sl_errAck = 1'b0;   // never signals errors
   assign Sl_retry  = 1'b0;

   opb_slave_fsm #(
      .C_BASEADDR (C_BASEADDR),
      .C_HIGHADDR (C_HIGHADDR)
   ) opb_fsm_i (
      .OPB_Clk    (OPB_Clk),
      .dram_rst   (dram_rst),
      .OPB_ABus   (OPB_ABus),
      .OPB_BE     (OPB_BE),
      .OPB_DBus   (OPB_DBus),
      .OPB_RNW    (OPB_RNW),
      .OPB_select (OPB_select),
      .Sl_DBus    (Sl_DBus),
      .Sl_xferAck (Sl_xferAck),
      .Sl_toutSup (Sl_toutSup),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .rd_done    (rd_done),
      .wr_done    (wr_done),
      .rd_data    (rd_data),
      .req_addr   (req_addr),
      .wr_data    (wr_data),
      .wr_be      (wr_be),
      .cpu_state  (cpu_state)
   );

   dram_access_fsm dram_fsm_i (
      .OPB_Clk            (OPB_Clk),
      .dram_rst           (dram_rst),
      .rd_req             (rd_req),
      .wr_req             (wr_req),
      .req_addr           (req_addr),
      .wr_data            (wr_data),
      .wr_be              (wr_be),
      .rd_done            (rd_done),
      .wr_done            (wr_done),
      .rd_data            (rd_data),
      .dram_rd_data       (dram_rd_data),
      .dram_rd_data_end   (dram_rd_data_end),
      .dram_rd_data_valid (dram_rd_data_valid),
      .dram_rdy           (dram_rdy),
      .dram_wdf_rdy       (dram_wdf_rdy),
      .dram_addr          (dram_addr),
      .dram_cmd           (dram_cmd),
      .dram_en            (dram_en),
      .dram_wdf_data      (dram_wdf_data),
      .dram_wdf_end       (dram_wdf_end),
      .dram_wdf_mask      (dram_wdf_mask),
      .dram_wdf_wren      (dram_wdf_wren),
      .dram_state         (dram_state)
   );

endmodule

// File: verif/mem_attach_checker.sv
`timescale 1ns/100ps

module mem_attach_checker (
   input logic               OPB_Clk,
   input logic               dram_rst,
   input logic               Sl_xferAck,
   input opb_pkg::opb_word_t Sl_DBus,
   input logic               dram_en,
   input logic               dram_rdy,
   input logic               dram_wdf_wren,
   input logic               dram_wdf_end
);

   ack_pulse_a: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      Sl_xferAck |=> !Sl_xferAck)
      else $error("Sl_xferAck high for more than one cycle");

   // command must wait for the controller
   en_hold_a: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      dram_en && !dram_rdy |=> dram_en)
      else $error("dram_en dropped before dram_rdy");

   end_wren_a: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      dram_wdf_end |-> dram_wdf_wren)
      else $error("dram_wdf_end high without dram_wdf_wren");

   dbus_idle_a: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      !Sl_xferAck |-> Sl_DBus == '0)
      else $error("Sl_DBus not zero outside the acknowledge");

endmodule

bind mem_opb_attach mem_attach_checker checker_i (.*);

// File: verif/mem_attach_tb.sv
`timescale 1ns/100ps
`include "mem_attach_macros.svh"

module mem_attach_tb;

   import opb_pkg::*;
   import dram_pkg::*;

   localparam int          CLK_PERIOD = 8;
   localparam int          NUM_TRANS  = 209;   // directed plus random
   localparam logic [31:0] BASE       = `MEM_BASEADDR;
   localparam logic [31:0] HIGH       = `MEM_HIGHADDR;

   logic        OPB_Clk = 1'b0;
   logic        dram_rst;
   opb_word_t   OPB_ABus;
   logic [0:3]  OPB_BE;
   opb_word_t   OPB_DBus;
   logic        OPB_RNW;
   logic        OPB_select;
   logic        OPB_seqAddr;
   opb_word_t   Sl_DBus;
   logic        Sl_errAck;
   logic        Sl_retry;
   logic        Sl_toutSup;
   logic        Sl_xferAck;
   dram_beat_t  dram_rd_data;
   logic        dram_rd_data_end;
   logic        dram_rd_data_valid;
   logic        dram_rdy;
   logic        dram_wdf_rdy;
   logic [31:0] dram_addr;
   dram_cmd_e   dram_cmd;
   logic        dram_en;
   dram_beat_t  dram_wdf_data;
   logic        dram_wdf_end;
   dram_mask_t  dram_wdf_mask;
   logic        dram_wdf_wren;
   dram_state_e dram_state;
   opb_state_e  cpu_state;

   int          seed = 99871;
   string       test_name = "reset";
   opb_word_t   shadow [logic [31:0]];     // expected contents by bus address
   logic [31:0] ctrl_mem [logic [31:0]];   // controller storage by offset
   logic        exp_read;
   opb_word_t   exp_word;
   logic [31:0] exp_addr;
   dram_cmd_e   exp_cmd;
   int          cmd_count;

   mem_opb_attach dut_i (.*);

   always #(CLK_PERIOD / 2) OPB_Clk = ~OPB_Clk;

   // byte lane i covers OPB bits 8i to 8i+7 and is enabled by be[i]
   function automatic opb_word_t expected_word(input opb_word_t  old_word,
                                               input opb_word_t  new_word,
                                               input logic [0:3] be);
      opb_word_t merged;
      merged = old_word;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            merged[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return merged;
   endfunction

   task automatic stop_run(input string what);
      $display("Verification failed");
      $fatal(1, "%s", what);
   endtask

   task automatic report_error(input string what);
      $display("ERROR in %s: %s", test_name, what);
      stop_run(what);
   endtask

   task automatic check_word(input string name, input opb_word_t exp, input opb_word_t act);
      if (act !== exp) begin
         $display("MISMATCH %s: read data expected %h, actual %h", name, exp, act);
         stop_run("read data mismatch");
      end
   endtask

   task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s: command address expected %h, actual %h", name, exp, act);
         stop_run("command address mismatch");
      end
   endtask

   task automatic check_cmd(input string name, input dram_cmd_e exp, input dram_cmd_e act);
      if (act !== exp) begin
         $display("MISMATCH %s: command expected %s, actual %s", name, exp.name(), act.name());
         stop_run("command code mismatch");
      end
   endtask

   task automatic check_opb_state(input string name, input opb_state_e exp,
                                  input opb_state_e act);
      if (act !== exp) begin
         $display("MISMATCH %s: bus fsm state expected %s, actual %s", name, exp.name(),
                  act.name());
         stop_run("bus fsm state mismatch");
      end
   endtask

   task automatic check_dram_state(input string name, input dram_state_e exp,
                                   input dram_state_e act);
      if (act !== exp) begin
         $display("MISMATCH %s: controller fsm state expected %s, actual %s", name,
                  exp.name(), act.name());
         stop_run("controller fsm state mismatch");
      end
   endtask

   // rdy and wdf_rdy drop about a third of the time
   initial begin : stall_source
      dram_rdy     = 1'b0;
      dram_wdf_rdy = 1'b0;
      forever begin
         @(posedge OPB_Clk);
         dram_rdy     <= ($random(seed) % 3) != 0;
         dram_wdf_rdy <= ($random(seed) % 3) != 0;
      end
   end

   // controller read side, two beats after a gap of 2 to 6 cycles
   initial begin : read_responder
      logic [31:0] word;
      logic [31:0] upper_fill;
      int          gap;
      dram_rd_data       = '0;
      dram_rd_data_valid = 1'b0;
      dram_rd_data_end   = 1'b0;
      forever begin
         @(posedge OPB_Clk);
         if (dram_en && dram_rdy && dram_cmd == DRAM_CMD_READ) begin
            word       = ctrl_mem.exists(dram_addr) ? ctrl_mem[dram_addr] : '0;
            upper_fill = $random(seed);
            gap        = 2 + int'($unsigned($random(seed)) % 5);
            repeat (gap) @(posedge OPB_Clk);
            dram_rd_data       <= {{8{upper_fill}}, word};
            dram_rd_data_valid <= 1'b1;
            @(posedge OPB_Clk);
            dram_rd_data       <= {{8{~upper_fill}}, ~word};   // must not be used
            dram_rd_data_end   <= 1'b1;
            @(posedge OPB_Clk);
            dram_rd_data_valid <= 1'b0;
            dram_rd_data_end   <= 1'b0;
         end
      end
   end

   // controller write side, first beat under its byte mask
   always @(posedge OPB_Clk) begin : write_sink
      logic [31:0] cmd_addr;
      logic [31:0] word;
      int          beat;
      if (dram_en && dram_rdy && dram_cmd == DRAM_CMD_WRITE) begin
         cmd_addr = dram_addr;
         beat     = 0;
      end
      if (dram_wdf_wren && dram_wdf_rdy) begin
         beat = beat + 1;
         if (beat > `DRAM_BURST_LEN) begin
            report_error("more write beats than one burst");
         end else if (dram_wdf_end !== (beat == `DRAM_BURST_LEN)) begin
            report_error("dram_wdf_end not on the last write beat");
         end
         if (beat == 1) begin
            word = ctrl_mem.exists(cmd_addr) ? ctrl_mem[cmd_addr] : '0;
            for (int k = 0; k < 4; k++) begin
               if (!dram_wdf_mask[k]) begin
                  word[8*k +: 8] = dram_wdf_data[8*k +: 8];
               end
            end
            ctrl_mem[cmd_addr] = word;
         end else if (dram_wdf_mask !== '1) begin
            report_error("second write beat not fully masked");
         end
      end
   end

   always @(posedge OPB_Clk) begin : compare_results
      if (dram_en && dram_rdy) begin
         cmd_count = cmd_count + 1;
         check_addr(test_name, exp_addr, dram_addr);
         check_cmd(test_name, exp_cmd, dram_cmd);
      end
      if (Sl_xferAck && exp_read) begin
         check_word(test_name, exp_word, Sl_DBus);
      end
      if (Sl_errAck || Sl_retry) begin
         report_error("error or retry output raised");
      end
   end

   task automatic bus_access(input logic rnw, input logic [31:0] addr,
                             input logic [0:3] be, input opb_word_t data);
      opb_word_t old_word;
      old_word  = shadow.exists(addr) ? shadow[addr] : '0;
      exp_read  = rnw;
      exp_word  = old_word;
      exp_addr  = addr - BASE;
      exp_cmd   = rnw ? DRAM_CMD_READ : DRAM_CMD_WRITE;
      cmd_count = 0;
      if (!rnw) begin
         shadow[addr] = expected_word(old_word, data, be);
      end
      @(posedge OPB_Clk);
      OPB_select <= 1'b1;
      OPB_RNW    <= rnw;
      OPB_ABus   <= addr;
      OPB_BE     <= be;
      OPB_DBus   <= data;
      @(posedge OPB_Clk);   // slave samples select here
      do begin
         @(posedge OPB_Clk);
         if (!Sl_xferAck && !Sl_toutSup) begin
            report_error("Sl_toutSup low while the access is pending");
         end
      end while (!Sl_xferAck);
      OPB_select <= 1'b0;
      OPB_RNW    <= 1'b0;
      OPB_ABus   <= '0;
      OPB_BE     <= '0;
      OPB_DBus   <= '0;
      @(posedge OPB_Clk);
      if (cmd_count != 1) begin
         report_error("expected exactly one controller command per access");
      end
      check_opb_state(test_name, OPB_IDLE, cpu_state);   // one cycle in OPB_DONE
   endtask

   // select outside the window, must be ignored
   task automatic stray_select(input logic [31:0] addr, input logic rnw);
      @(posedge OPB_Clk);
      OPB_select <= 1'b1;
      OPB_RNW    <= rnw;
      OPB_ABus   <= addr;
      OPB_BE     <= 4'hF;
      OPB_DBus   <= 32'h5A5A_A5A5;
      repeat (50) begin
         @(posedge OPB_Clk);
         if (Sl_xferAck || Sl_toutSup) begin
            report_error("slave responded to an address outside its window");
         end
         if (dram_en) begin
            report_error("controller command for an address outside the window");
         end
      end
      OPB_select <= 1'b0;
      OPB_ABus   <= '0;
      @(posedge OPB_Clk);
   endtask

   initial begin : watchdog
      #(CLK_PERIOD * 200 * NUM_TRANS);
      $display("ERROR: watchdog expired before all transactions completed");
      stop_run("watchdog expired");
   end

   initial begin : main_sequence
      int          rnd;
      logic [31:0] addr;
      dram_rst    = 1'b1;
      OPB_select  = 1'b0;
      OPB_RNW     = 1'b0;
      OPB_ABus    = '0;
      OPB_BE      = '0;
      OPB_DBus    = '0;
      OPB_seqAddr = 1'b0;
      exp_read    = 1'b0;
      cmd_count   = 0;
      repeat (2) @(posedge OPB_Clk);
      // outputs as left by reset, still asserted here
      check_opb_state(test_name, OPB_IDLE, cpu_state);
      check_dram_state(test_name, DRAM_IDLE, dram_state);
      if ({Sl_xferAck, Sl_toutSup, dram_en, dram_wdf_wren, dram_wdf_end} !== 5'b0) begin
         report_error("control outputs not cleared by reset");
      end
      dram_rst <= 1'b0;

      test_name = "full_word";
      bus_access(1'b0, BASE + 32'h10, 4'hF, 32'hDEAD_BEEF);
      bus_access(1'b1, BASE + 32'h10, 4'hF, '0);

      test_name = "partial_be";
      bus_access(1'b0, BASE + 32'h24, 4'hF, 32'h1122_3344);
      bus_access(1'b0, BASE + 32'h24, 4'b0101, 32'hAABB_CCDD);
      bus_access(1'b1, BASE + 32'h24, 4'hF, '0);

      test_name = "window_top";   // largest offset in the window
      bus_access(1'b0, HIGH - 32'd3, 4'b1001, 32'hCAFE_F00D);
      bus_access(1'b1, HIGH - 32'd3, 4'hF, '0);

      test_name = "out_of_window";
      stray_select(HIGH + 32'd1, 1'b1);
      stray_select(BASE - 32'd4, 1'b0);

      test_name = "random";
      repeat (200) begin
         rnd  = $random(seed);
         addr = BASE + {26'd0, rnd[7:4], 2'b00};   // 16 words, many reuses
         bus_access(rnd[8], addr, rnd[8] ? 4'hF : rnd[3:0], $random(seed));
      end

      $display("Verification passed");
      $finish;
   end

endmodule

// File: tb.f
+incdir+src
src/opb_pkg.sv
src/dram_pkg.sv
src/opb_slave_fsm.sv
src/dram_access_fsm.sv
src/mem_opb_attach.sv
verif/mem_attach_checker.sv
verif/mem_attach_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the memory attachment testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_attach_tb \
   -f tb.f \
   -o mem_attach_sim

# a failing run ends in $fatal, which gives a non-zero exit status
./obj_dir/mem_attach_sim
